//--- rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////
// Fetch stage widths and sizes
////////////////////////////////////////

// Address and instruction word width
`define XLEN 32

// Number of buffer slots
// Also bounds the requests in flight
`define FETCH_DEPTH 3

// Slot index and small counter width
`define SLOT_IDX_W 2

// Upper bits of the trap vector base
`define MTVEC_BASE_W 25

// Interrupt id width for vectored traps
`define IRQ_ID_W 5

`endif

//--- rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // One fetch address
  typedef logic [`XLEN-1:0] addr_t;

  // One raw instruction word from the bus
  typedef logic [`XLEN-1:0] instr_t;

  // Redirect target selector from the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  // Buffer slot life cycle
  typedef enum logic [1:0] {
    SLOT_EMPTY   = 2'd0,
    SLOT_PENDING = 2'd1,
    SLOT_FULL    = 2'd2
  } slot_state_e;

endpackage

`default_nettype wire

//--- rtl/fetch_requester.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_requester (
  input  logic                     clk,
  input  logic                     rst_n,
  // Redirect from the controller
  input  logic                     pc_set_i,
  input  fetch_pkg::pc_mux_e       pc_mux_i,
  input  fetch_pkg::addr_t         boot_addr_i,
  input  fetch_pkg::addr_t         jump_target_i,
  input  fetch_pkg::addr_t         branch_target_i,
  input  fetch_pkg::addr_t         mepc_i,
  input  logic [`MTVEC_BASE_W-1:0] mtvec_base_i,
  input  logic [`IRQ_ID_W-1:0]     irq_id_i,
  // A full slot was consumed by IF/ID
  input  logic                     pop_i,
  // Instruction bus
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic                     instr_err_i,
  input  fetch_pkg::instr_t        instr_rdata_i,
  output logic                     instr_req_o,
  output fetch_pkg::addr_t         instr_addr_o,
  // Slot strobes
  output logic [`FETCH_DEPTH-1:0]  alloc_o,
  output logic [`FETCH_DEPTH-1:0]  fill_o,
  output fetch_pkg::addr_t         alloc_addr_o,
  output fetch_pkg::instr_t        fill_data_o,
  output logic                     fill_err_o,
  // Status
  output logic                     busy_o,
  output logic                     mtvec_init_o
);

  import fetch_pkg::*;

  addr_t                  branch_addr;
  addr_t                  fetch_addr_q;
  logic                   active_q;
  logic                   gnt_acc;
  logic                   resp_keep;
  logic [`SLOT_IDX_W-1:0] alloc_ptr_q;
  logic [`SLOT_IDX_W-1:0] fill_ptr_q;
  // Pending plus full slots
  logic [`SLOT_IDX_W-1:0] occ_q;
  // Granted requests still owed a response
  logic [`SLOT_IDX_W-1:0] inflight_q;
  logic [`SLOT_IDX_W-1:0] inflight_n;
  // Responses of killed requests still to drop
  logic [`SLOT_IDX_W-1:0] discard_q;

  // Slot pointer step with wrap at the last slot
  function automatic logic [`SLOT_IDX_W-1:0] ptr_inc(input logic [`SLOT_IDX_W-1:0] ptr);
    if (ptr == `SLOT_IDX_W'(`FETCH_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Redirect target
  ////////////////////////////////////////

  always_comb begin
    // Boot word address unless a case below picks another
    branch_addr = {boot_addr_i[`XLEN-1:2], 2'b00};
    unique case (pc_mux_i)
      PC_BOOT:     branch_addr = {boot_addr_i[`XLEN-1:2], 2'b00};
      PC_JUMP:     branch_addr = jump_target_i;
      PC_BRANCH:   branch_addr = branch_target_i;
      // Return to the saved exception PC
      PC_MRET:     branch_addr = mepc_i;
      // All exceptions share the trap base
      PC_TRAP_EXC: branch_addr = {mtvec_base_i, 7'h00};
      // Interrupts are vectored by id
      PC_TRAP_IRQ: branch_addr = {mtvec_base_i, irq_id_i, 2'b00};
      default:     branch_addr = {boot_addr_i[`XLEN-1:2], 2'b00};
    endcase
  end

  // CSR file sets up mtvec on boot
  assign mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////
  // Request issue and response routing
  ////////////////////////////////////////

  // Request only with a free slot and no stale responses owed
  assign instr_req_o  = active_q && (occ_q != `SLOT_IDX_W'(`FETCH_DEPTH)) &&
                        (discard_q == '0);
  assign instr_addr_o = fetch_addr_q;
  assign gnt_acc      = instr_req_o && instr_gnt_i;

  // Responses after the discards belong to live slots
  assign resp_keep  = instr_rvalid_i && (discard_q == '0);
  assign inflight_n = inflight_q + `SLOT_IDX_W'(gnt_acc) - `SLOT_IDX_W'(instr_rvalid_i);

  always_comb begin
    for (int i = 0; i < `FETCH_DEPTH; i++) begin
      alloc_o[i] = gnt_acc && (alloc_ptr_q == `SLOT_IDX_W'(i));
      fill_o[i]  = resp_keep && (fill_ptr_q == `SLOT_IDX_W'(i));
    end
  end

  assign alloc_addr_o = fetch_addr_q;
  assign fill_data_o  = instr_rdata_i;
  assign fill_err_o   = instr_err_i;
  assign busy_o       = (inflight_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      alloc_ptr_q  <= '0;
      fill_ptr_q   <= '0;
      occ_q        <= '0;
      inflight_q   <= '0;
      discard_q    <= '0;
    end else begin
      inflight_q <= inflight_n;
      if (pc_set_i) begin
        // Flush turns every request still out into a discard
        active_q     <= 1'b1;
        fetch_addr_q <= branch_addr;
        alloc_ptr_q  <= '0;
        fill_ptr_q   <= '0;
        occ_q        <= '0;
        discard_q    <= inflight_n;
      end else begin
        occ_q <= occ_q + `SLOT_IDX_W'(gnt_acc) - `SLOT_IDX_W'(pop_i);
        if (gnt_acc) begin
          fetch_addr_q <= fetch_addr_q + `XLEN'd4;
          alloc_ptr_q  <= ptr_inc(alloc_ptr_q);
        end
        if (resp_keep) begin
          fill_ptr_q <= ptr_inc(fill_ptr_q);
        end
        // Drop one stale response
        if (instr_rvalid_i && (discard_q != '0)) begin
          discard_q <= discard_q - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/fetch_slot.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_slot (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  // Strobes from the requester and IF/ID
  input  logic                   alloc_i,
  input  logic                   fill_i,
  input  logic                   release_i,
  input  logic                   fill_err_i,
  input  fetch_pkg::addr_t       alloc_addr_i,
  input  fetch_pkg::instr_t      fill_data_i,
  // Slot contents
  output fetch_pkg::slot_state_e state_o,
  output fetch_pkg::addr_t       addr_o,
  output fetch_pkg::instr_t      data_o,
  output logic                   err_o
);

  import fetch_pkg::*;

  slot_state_e state_q;
  addr_t       addr_q;
  instr_t      data_q;
  logic        err_q;

  // Empty -> pending -> full -> empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= SLOT_EMPTY;
    end else if (flush_i) begin
      state_q <= SLOT_EMPTY;
    end else begin
      unique case (state_q)
        SLOT_EMPTY:   if (alloc_i)   state_q <= SLOT_PENDING;
        SLOT_PENDING: if (fill_i)    state_q <= SLOT_FULL;
        SLOT_FULL:    if (release_i) state_q <= SLOT_EMPTY;
        default:      state_q <= SLOT_EMPTY;
      endcase
    end
  end

  // Payload captured with its strobe
  always_ff @(posedge clk) begin
    if (alloc_i) begin
      addr_q <= alloc_addr_i;
    end
    if (fill_i) begin
      data_q <= fill_data_i;
      err_q  <= fill_err_i;
    end
  end

  assign state_o = state_q;
  assign addr_o  = addr_q;
  assign data_o  = data_q;
  assign err_o   = err_q;

endmodule

`default_nettype wire

//--- rtl/if_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module if_id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic                    halt_i,
  input  logic                    id_ready_i,
  // Slot contents
  input  fetch_pkg::slot_state_e  slot_state_i [`FETCH_DEPTH],
  input  fetch_pkg::addr_t        slot_addr_i  [`FETCH_DEPTH],
  input  fetch_pkg::instr_t       slot_data_i  [`FETCH_DEPTH],
  input  logic [`FETCH_DEPTH-1:0] slot_err_i,
  // Consumed slot back to the buffer
  output logic [`FETCH_DEPTH-1:0] release_o,
  output logic                    pop_o,
  // IF/ID pipeline register
  output logic                    if_id_valid_o,
  output fetch_pkg::addr_t        if_id_pc_o,
  output fetch_pkg::instr_t       if_id_instr_o,
  output logic                    if_id_err_o
);

  import fetch_pkg::*;

  logic [`SLOT_IDX_W-1:0] rd_ptr_q;
  logic                   instr_valid;
  logic                   transfer;
  addr_t                  pc_q;
  instr_t                 instr_q;
  logic                   err_q;
  logic                   valid_q;

  ////////////////////////////////////////
  // Oldest slot selection
  ////////////////////////////////////////

  // Oldest slot holds a word and IF is not halted
  assign instr_valid = (slot_state_i[rd_ptr_q] == SLOT_FULL) && !halt_i;
  // No handoff while a redirect kills the buffer
  assign transfer    = instr_valid && id_ready_i && !flush_i;
  assign pop_o       = transfer;

  always_comb begin
    for (int i = 0; i < `FETCH_DEPTH; i++) begin
      release_o[i] = transfer && (rd_ptr_q == `SLOT_IDX_W'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
    end else if (transfer) begin
      rd_ptr_q <= (rd_ptr_q == `SLOT_IDX_W'(`FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  // Valid drops when ID takes the word and nothing follows
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (transfer) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload frozen while ID stalls
  always_ff @(posedge clk) begin
    if (transfer) begin
      pc_q    <= slot_addr_i[rd_ptr_q];
      instr_q <= slot_data_i[rd_ptr_q];
      err_q   <= slot_err_i[rd_ptr_q];
    end
  end

  assign if_id_valid_o = valid_q;
  assign if_id_pc_o    = pc_q;
  assign if_id_instr_o = instr_q;
  assign if_id_err_o   = err_q;

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  // Redirect control
  input  logic                     pc_set_i,
  input  fetch_pkg::pc_mux_e       pc_mux_i,
  input  fetch_pkg::addr_t         boot_addr_i,
  input  fetch_pkg::addr_t         jump_target_i,
  input  fetch_pkg::addr_t         branch_target_i,
  input  fetch_pkg::addr_t         mepc_i,
  input  logic [`MTVEC_BASE_W-1:0] mtvec_base_i,
  input  logic [`IRQ_ID_W-1:0]     irq_id_i,
  input  logic                     halt_if_i,
  input  logic                     id_ready_i,
  // Instruction bus
  output logic                     instr_req_o,
  output fetch_pkg::addr_t         instr_addr_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  fetch_pkg::instr_t        instr_rdata_i,
  input  logic                     instr_err_i,
  // IF/ID pipeline
  output logic                     if_id_valid_o,
  output fetch_pkg::addr_t         if_id_pc_o,
  output fetch_pkg::instr_t        if_id_instr_o,
  output logic                     if_id_err_o,
  // Status
  output logic                     csr_mtvec_init_o,
  output logic                     if_busy_o
);

  import fetch_pkg::*;

  logic [`FETCH_DEPTH-1:0] alloc;
  logic [`FETCH_DEPTH-1:0] fill;
  logic [`FETCH_DEPTH-1:0] slot_release;
  addr_t                   alloc_addr;
  instr_t                  fill_data;
  logic                    fill_err;
  logic                    pop;
  slot_state_e             slot_state [`FETCH_DEPTH];
  addr_t                   slot_addr  [`FETCH_DEPTH];
  instr_t                  slot_data  [`FETCH_DEPTH];
  logic [`FETCH_DEPTH-1:0] slot_err;

  // Next PC, bus requests and response routing
  fetch_requester i_requester (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_base_i    (mtvec_base_i),
    .irq_id_i        (irq_id_i),
    .pop_i           (pop),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_err_i     (instr_err_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .alloc_o         (alloc),
    .fill_o          (fill),
    .alloc_addr_o    (alloc_addr),
    .fill_data_o     (fill_data),
    .fill_err_o      (fill_err),
    .busy_o          (if_busy_o),
    .mtvec_init_o    (csr_mtvec_init_o)
  );

  // Fetch buffer slots
  for (genvar g = 0; g < `FETCH_DEPTH; g++) begin : gen_slot
    fetch_slot i_slot (
      .clk          (clk),
      .rst_n        (rst_n),
      .flush_i      (pc_set_i),
      .alloc_i      (alloc[g]),
      .fill_i       (fill[g]),
      .release_i    (slot_release[g]),
      .fill_err_i   (fill_err),
      .alloc_addr_i (alloc_addr),
      .fill_data_i  (fill_data),
      .state_o      (slot_state[g]),
      .addr_o       (slot_addr[g]),
      .data_o       (slot_data[g]),
      .err_o        (slot_err[g])
    );
  end

  // In-order handoff to decode
  if_id_stage i_if_id (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (pc_set_i),
    .halt_i        (halt_if_i),
    .id_ready_i    (id_ready_i),
    .slot_state_i  (slot_state),
    .slot_addr_i   (slot_addr),
    .slot_data_i   (slot_data),
    .slot_err_i    (slot_err),
    .release_o     (slot_release),
    .pop_o         (pop),
    .if_id_valid_o (if_id_valid_o),
    .if_id_pc_o    (if_id_pc_o),
    .if_id_instr_o (if_id_instr_o),
    .if_id_err_o   (if_id_err_o)
  );

endmodule

`default_nettype wire

//--- sim/fetch_stage_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage_properties (
  input logic             clk,
  input logic             rst_n,
  input logic             pc_set_i,
  input logic             instr_req_i,
  input fetch_pkg::addr_t instr_addr_i,
  input logic             instr_gnt_i,
  input logic             instr_rvalid_i,
  input logic             if_id_valid_i
);

  // Granted requests still owed a response
  logic [2:0] outstanding_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(instr_req_i && instr_gnt_i) - 3'(instr_rvalid_i);
    end
  end

  // Request and address hold until grant
  // A redirect may withdraw an ungranted request
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_i && !instr_gnt_i && !pc_set_i) |=> (instr_req_i && $stable(instr_addr_i)))
    else $error("Request or address changed before grant");

  a_outstanding_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= 3'(`FETCH_DEPTH))
    else $error("More than %0d requests in flight", `FETCH_DEPTH);

  a_valid_after_reset: assert property (@(posedge clk)
    !rst_n |=> !if_id_valid_i)
    else $error("IF/ID valid high right after reset");

endmodule

bind fetch_stage fetch_stage_properties i_properties (
  .clk            (clk),
  .rst_n          (rst_n),
  .pc_set_i       (pc_set_i),
  .instr_req_i    (instr_req_o),
  .instr_addr_i   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .if_id_valid_i  (if_id_valid_o)
);

`default_nettype wire

//--- sim/fetch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_stage_tb;

  import fetch_pkg::*;

  // Run bound from tests, words per test and cycles per word
  localparam int num_tests       = 6;
  localparam int words_per_test  = 200;
  localparam int cycles_per_word = 12;
  localparam int timeout_cycles  = num_tests * words_per_test * cycles_per_word;

  logic                     clk;
  logic                     rst_n;
  logic                     pc_set_i;
  pc_mux_e                  pc_mux_i;
  addr_t                    boot_addr_i;
  addr_t                    jump_target_i;
  addr_t                    branch_target_i;
  addr_t                    mepc_i;
  logic [`MTVEC_BASE_W-1:0] mtvec_base_i;
  logic [`IRQ_ID_W-1:0]     irq_id_i;
  logic                     halt_if_i;
  logic                     id_ready_i;
  logic                     instr_req_o;
  addr_t                    instr_addr_o;
  logic                     instr_gnt_i;
  logic                     instr_rvalid_i;
  instr_t                   instr_rdata_i;
  logic                     instr_err_i;
  logic                     if_id_valid_o;
  addr_t                    if_id_pc_o;
  instr_t                   if_id_instr_o;
  logic                     if_id_err_o;
  logic                     csr_mtvec_init_o;
  logic                     if_busy_o;

  integer seed = 33488;
  // Memory model queues of granted addresses and their answer cycles
  addr_t  gnt_addr_q[$];
  int     due_q[$];
  int     mem_cycle;
  int     last_due;
  // Random ready and halt on ID side
  bit     stress_en;
  // Reference model
  addr_t  exp_pc;
  bit     pc_known;
  bit     req_due;
  addr_t  req_addr_exp;
  bit     hold_armed;
  addr_t  held_pc;
  instr_t held_instr;
  logic   held_err;
  int     delivered;
  int     err_words;
  // Granted bus requests not yet answered
  int     owed;
  // Scoreboard
  int     checks;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_err_start;
  int     cycle_cnt;

  fetch_stage i_fetch_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_base_i     (mtvec_base_i),
    .irq_id_i         (irq_id_i),
    .halt_if_i        (halt_if_i),
    .id_ready_i       (id_ready_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .if_id_valid_o    (if_id_valid_o),
    .if_id_pc_o       (if_id_pc_o),
    .if_id_instr_o    (if_id_instr_o),
    .if_id_err_o      (if_id_err_o),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .if_busy_o        (if_busy_o)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Memory rules and target rules
  ////////////////////////////////////////

  // Memory word is the inverted address
  function automatic instr_t mem_word(input addr_t addr);
    return ~addr;
  endfunction

  // Bus error window where address bits 11..8 are all set
  function automatic logic mem_err(input addr_t addr);
    return &addr[11:8];
  endfunction

  function automatic addr_t redirect_target(input pc_mux_e mux, input addr_t boot,
                                            input addr_t jump, input addr_t branch,
                                            input addr_t mepc,
                                            input logic [`MTVEC_BASE_W-1:0] base,
                                            input logic [`IRQ_ID_W-1:0] irq);
    case (mux)
      PC_JUMP:     return jump;
      PC_BRANCH:   return branch;
      PC_MRET:     return mepc;
      // Trap base followed by seven zero bits
      PC_TRAP_EXC: return {base, 7'b0};
      // Trap base with irq id and word offset
      PC_TRAP_IRQ: return {base, irq, 2'b00};
      default:     return {boot[`XLEN-1:2], 2'b00};
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  ////////////////////////////////////////
  // Bus memory and ID side drivers
  ////////////////////////////////////////

  always @(posedge clk) begin
    int lat;
    int due;
    if (!rst_n) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
      instr_err_i    <= 1'b0;
      id_ready_i     <= 1'b1;
      halt_if_i      <= 1'b0;
      gnt_addr_q.delete();
      due_q.delete();
      last_due = 0;
    end else begin
      // Granted at this edge and answered in order 1 to 4 cycles later
      if (instr_req_o && instr_gnt_i) begin
        lat = 1 + ($random(seed) & 3);
        due = mem_cycle + lat - 1;
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        gnt_addr_q.push_back(instr_addr_o);
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= mem_cycle) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(gnt_addr_q[0]);
        instr_err_i    <= mem_err(gnt_addr_q[0]);
        void'(gnt_addr_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_rdata_i  <= '0;
        instr_err_i    <= 1'b0;
      end
      instr_gnt_i <= (($random(seed) & 3) != 0);
      if (stress_en) begin
        id_ready_i <= (($random(seed) & 3) != 0);
        halt_if_i  <= (($random(seed) & 7) == 0);
      end else begin
        id_ready_i <= 1'b1;
        halt_if_i  <= 1'b0;
      end
    end
    mem_cycle++;
  end

  ////////////////////////////////////////
  // Reference model and output checks
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      // mtvec init strobe only with a boot redirect
      check_bit("csr_mtvec_init_o", csr_mtvec_init_o, pc_set_i && (pc_mux_i == PC_BOOT));
      // Busy while a granted request still waits for its response
      check_bit("if_busy_o", if_busy_o, owed != 0);
      if (!pc_known) begin
        check_bit("instr_req_o", instr_req_o, 1'b0);
      end
      // First request one cycle after an idle redirect
      if (req_due) begin
        check_bit("instr_req_o", instr_req_o, 1'b1);
        check_addr("instr_addr_o", instr_addr_o, req_addr_exp);
      end
      // ID stalled last cycle so IF/ID must hold
      if (hold_armed) begin
        check_bit("if_id_valid_o", if_id_valid_o, 1'b1);
        check_addr("if_id_pc_o", if_id_pc_o, held_pc);
        check_instr("if_id_instr_o", if_id_instr_o, held_instr);
        check_bit("if_id_err_o", if_id_err_o, held_err);
      end
      if (if_id_valid_o && id_ready_i) begin
        if (!pc_known) begin
          report_failure("Word handed to ID before any redirect");
        end else begin
          check_addr("if_id_pc_o", if_id_pc_o, exp_pc);
          check_instr("if_id_instr_o", if_id_instr_o, mem_word(exp_pc));
          check_bit("if_id_err_o", if_id_err_o, mem_err(exp_pc));
          if (if_id_err_o) begin
            err_words++;
          end
          delivered++;
          exp_pc = exp_pc + `XLEN'd4;
        end
      end
      hold_armed = if_id_valid_o && !id_ready_i && !pc_set_i;
      held_pc    = if_id_pc_o;
      held_instr = if_id_instr_o;
      held_err   = if_id_err_o;
      req_due    = 1'b0;
      if (pc_set_i) begin
        exp_pc = redirect_target(pc_mux_i, boot_addr_i, jump_target_i, branch_target_i,
                                 mepc_i, mtvec_base_i, irq_id_i);
        // Nothing owed on the bus and no grant now means no discards
        req_due      = (owed == 0) && !(instr_req_o && instr_gnt_i);
        req_addr_exp = exp_pc;
        pc_known     = 1'b1;
      end
      if (instr_req_o && instr_gnt_i) begin
        owed++;
      end
      if (instr_rvalid_i) begin
        owed--;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, %0d words delivered", cycle_cnt, delivered);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One-cycle redirect pulse with fresh random targets
  task automatic redirect(input pc_mux_e mux, input addr_t boot);
    addr_t r_jump;
    addr_t r_branch;
    addr_t r_mepc;
    addr_t r_trap;
    r_jump   = $random(seed);
    r_branch = $random(seed);
    r_mepc   = $random(seed);
    r_trap   = $random(seed);
    @(posedge clk);
    pc_set_i        <= 1'b1;
    pc_mux_i        <= mux;
    boot_addr_i     <= boot;
    jump_target_i   <= {r_jump[`XLEN-1:2], 2'b00};
    branch_target_i <= {r_branch[`XLEN-1:2], 2'b00};
    mepc_i          <= {r_mepc[`XLEN-1:2], 2'b00};
    mtvec_base_i    <= r_trap[`XLEN-1:`XLEN-`MTVEC_BASE_W];
    irq_id_i        <= r_trap[`IRQ_ID_W-1:0];
    @(posedge clk);
    pc_set_i <= 1'b0;
  endtask

  task automatic wait_words(input int n);
    int target;
    @(negedge clk);
    target = delivered + n;
    while (delivered < target) begin
      @(negedge clk);
    end
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = errors - test_err_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "FAILED", errs);
  endtask

  initial begin
    int      n_idle;
    int      err_start;
    pc_mux_e mux;
    addr_t   r;
    clk             = 1'b0;
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_base_i    = '0;
    irq_id_i        = '0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    stress_en       = 1'b0;
    pc_known        = 1'b0;
    req_due         = 1'b0;
    hold_armed      = 1'b0;
    exp_pc          = '0;
    delivered       = 0;
    err_words       = 0;
    owed            = 0;
    checks          = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cycle_cnt       = 0;
    mem_cycle       = 0;
    last_due        = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // No request after reset until a redirect
    start_test();
    @(negedge clk);
    check_bit("instr_req_o", instr_req_o, 1'b0);
    check_bit("if_id_valid_o", if_id_valid_o, 1'b0);
    check_bit("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);
    check_bit("if_busy_o", if_busy_o, 1'b0);
    repeat (5) @(negedge clk);
    finish_test("reset");

    start_test();
    redirect(PC_BOOT, $random(seed));
    wait_words(40);
    finish_test("boot");

    start_test();
    wait_words(150);
    finish_test("sequential");

    // Every selector once at a random point in the stream
    start_test();
    mux = PC_BOOT;
    for (int i = 0; i < 6; i++) begin
      n_idle = $random(seed) & 7;
      repeat (n_idle) @(negedge clk);
      redirect(mux, $random(seed));
      wait_words(25);
      mux = mux.next();
    end
    finish_test("redirect");

    // Random ID stalls and halts with redirects in between
    start_test();
    stress_en <= 1'b1;
    wait_words(50);
    for (int i = 0; i < 2; i++) begin
      mux = pc_mux_e'(3'({$random(seed)} % 6));
      redirect(mux, $random(seed));
      wait_words(50);
    end
    stress_en <= 1'b0;
    finish_test("backpressure");

    // Boot 16 words below the window at 0xF00 and run 64 words through it
    start_test();
    r       = $random(seed);
    r[11:2] = 10'h3B0;
    redirect(PC_BOOT, r);
    @(negedge clk);
    err_start = err_words;
    wait_words(100);
    if (err_words - err_start != 64) begin
      report_failure($sformatf("Bus error window flagged %0d words instead of 64",
                               err_words - err_start));
    end
    finish_test("bus_error");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fetch_stage.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_requester.sv
rtl/fetch_slot.sv
rtl/if_id_stage.sv
rtl/fetch_stage.sv
sim/fetch_stage_properties.sv
sim/fetch_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fetch_stage_tb
FILELIST  ?= fetch_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
